/* fpu_pkg.sv */
package fpu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Single precision format
    ////////////////////////////////////////////////////////////////////////////
    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 23;
    localparam int WORD_W   = 32;
    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;     // All-ones exponent

    // Normalizer input, binary point sits between bits 46 and 45
    localparam int WORK_W   = 48;

    // Special encodings, sign bit excluded
    localparam logic [WORD_W-2:0] QNAN_WORD = 31'h7fc0_0001;
    localparam logic [WORD_W-2:0] INF_WORD  = 31'h7f80_0000;

    // Register stages from operand input to result output
    localparam int PIPE_LATENCY = 4;

    // Code 3 is reserved and runs as an add
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } fpu_op_t;

endpackage

/* fpu_ctrl_pipe.sv */
module fpu_ctrl_pipe #(
    parameter int PIPE_LATENCY = fpu_pkg::PIPE_LATENCY
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [fpu_pkg::WORD_W-1:0] opa,
    input  logic [fpu_pkg::WORD_W-1:0] opb,
    input  fpu_pkg::fpu_op_t           fpu_op,
    output logic [fpu_pkg::WORD_W-1:0] opa_r,
    output logic [fpu_pkg::WORD_W-1:0] opb_r,
    output fpu_pkg::fpu_op_t           op_s1,
    output fpu_pkg::fpu_op_t           op_s2
);
    import fpu_pkg::*;

    // Op code is needed up to the normalizer stage, the output stage does not
    // look at it
    localparam int OP_DEPTH = PIPE_LATENCY - 2;

    fpu_op_t op_pipe [OP_DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            opa_r <= '0;
            opb_r <= '0;
            for (int i = 0; i < OP_DEPTH; i++) begin
                op_pipe[i] <= OP_ADD;
            end
        end else begin
            opa_r      <= opa;
            opb_r      <= opb;
            op_pipe[0] <= fpu_op;
            for (int i = 1; i < OP_DEPTH; i++) begin
                op_pipe[i] <= op_pipe[i-1];
            end
        end
    end

    assign op_s1 = op_pipe[0];   // Steers except, align
    assign op_s2 = op_pipe[1];   // Steers post_norm input select

    // Normalizer must see the op that fed the stage 1 registers
    a_op_follow: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> op_s2 == $past(op_s1));

endmodule

/* fpu_except.sv */
module fpu_except (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [fpu_pkg::WORD_W-1:0] opa_r,
    input  logic [fpu_pkg::WORD_W-1:0] opb_r,
    input  fpu_pkg::fpu_op_t           op_s1,
    output logic                       special_valid,
    output logic [fpu_pkg::WORD_W-1:0] special_word,
    output logic                       special_inf,
    output logic                       special_qnan,
    output logic                       special_snan,
    output logic                       special_zero
);
    import fpu_pkg::*;

    // Returns {nan, snan, inf, zero}; denormals count as zero
    function automatic logic [3:0] classify(input logic [WORD_W-1:0] w);
        logic [EXP_W-1:0]  e;
        logic [FRAC_W-1:0] f;
        logic              e_max;
        e     = w[WORD_W-2 -: EXP_W];
        f     = w[FRAC_W-1:0];
        e_max = (e == EXP_W'(EXP_MAX));
        return {e_max && f != '0, e_max && f != '0 && !f[FRAC_W-1],
                e_max && f == '0, e == '0};
    endfunction

    logic       a_nan, a_snan, a_inf, a_zero;
    logic       b_nan, b_snan, b_inf, b_zero;
    logic       is_mul, is_sub, eff_sub, invalid, inf_sign;
    logic       d_valid, d_inf, d_qnan, d_snan, d_zero;
    logic [WORD_W-1:0] d_word;
    logic [WORD_W+4:0] dec_r1, dec_r2;   // {valid, word, inf, qnan, snan, zero}

    assign {a_nan, a_snan, a_inf, a_zero} = classify(opa_r);
    assign {b_nan, b_snan, b_inf, b_zero} = classify(opb_r);

    assign is_mul  = (op_s1 == OP_MUL);
    assign is_sub  = (op_s1 == OP_SUB);
    assign eff_sub = opa_r[WORD_W-1] ^ opb_r[WORD_W-1] ^ is_sub;

    // inf - inf, inf * 0
    assign invalid = is_mul ? ((a_inf && b_zero) || (b_inf && a_zero))
                            : (a_inf && b_inf && eff_sub);

    assign inf_sign = is_mul ? opa_r[WORD_W-1] ^ opb_r[WORD_W-1]
                    : a_inf  ? opa_r[WORD_W-1]
                    :          opb_r[WORD_W-1] ^ is_sub;

    // Priority follows IEEE: NaN, invalid, infinity, multiply by zero
    always_comb begin
        d_valid = 1'b1;
        d_word  = '0;
        d_inf   = 1'b0;
        d_qnan  = 1'b0;
        d_snan  = 1'b0;
        d_zero  = 1'b0;
        if (a_nan || b_nan) begin
            d_word = {1'b0, QNAN_WORD};
            d_qnan = 1'b1;
            d_snan = a_snan || b_snan;
        end else if (invalid) begin
            d_word = {1'b0, QNAN_WORD};
            d_qnan = 1'b1;
        end else if (a_inf || b_inf) begin
            d_word = {inf_sign, INF_WORD};
            d_inf  = 1'b1;
        end else if (is_mul && (a_zero || b_zero)) begin
            d_word = {opa_r[WORD_W-1] ^ opb_r[WORD_W-1], {(WORD_W-1){1'b0}}};
            d_zero = 1'b1;
        end else begin
            d_valid = 1'b0;   // Add with a zero goes down the normal path
        end
    end

    // Second register lines up with the normalizer output
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_r1 <= '0;
            dec_r2 <= '0;
        end else begin
            dec_r1 <= {d_valid, d_word, d_inf, d_qnan, d_snan, d_zero};
            dec_r2 <= dec_r1;
        end
    end

    assign {special_valid, special_word, special_inf, special_qnan,
            special_snan, special_zero} = dec_r2;

    a_nan_not_inf: assert property (@(posedge clk) disable iff (!rst_n)
        !(special_qnan && special_inf));

endmodule

/* fpu_addsub_align.sv */
module fpu_addsub_align (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [fpu_pkg::WORD_W-1:0]        opa_r,
    input  logic [fpu_pkg::WORD_W-1:0]        opb_r,
    input  fpu_pkg::fpu_op_t                  op_s1,
    output logic [fpu_pkg::WORK_W-1:0]        as_fract,
    output logic signed [fpu_pkg::EXP_W+1:0]  as_exp,
    output logic                              as_sign
);
    import fpu_pkg::*;

    logic                  sign_a, sign_b, eff_sub, swap, sign_l;
    logic [EXP_W-1:0]      exp_a, exp_b, exp_l, exp_s, exp_diff;
    logic [FRAC_W:0]       mant_a, mant_b, mant_l, mant_s;
    logic [4:0]            shift;
    logic [2*FRAC_W+3:0]   shifted;
    logic [FRAC_W+3:0]     big_f, small_f;   // hidden, fraction, G, R, S
    logic [FRAC_W+4:0]     sum;              // plus carry

    assign exp_a  = opa_r[WORD_W-2 -: EXP_W];
    assign exp_b  = opb_r[WORD_W-2 -: EXP_W];
    assign mant_a = (exp_a == '0) ? '0 : {1'b1, opa_r[FRAC_W-1:0]};  // Denormal as zero
    assign mant_b = (exp_b == '0) ? '0 : {1'b1, opb_r[FRAC_W-1:0]};

    // Subtract is an add of the negated opb
    assign sign_a  = opa_r[WORD_W-1];
    assign sign_b  = opb_r[WORD_W-1] ^ (op_s1 == OP_SUB);
    assign eff_sub = sign_a ^ sign_b;

    ////////////////////////////////////////////////////////////////////////////
    // Magnitude sort and alignment
    ////////////////////////////////////////////////////////////////////////////
    assign swap     = {exp_b, mant_b} > {exp_a, mant_a};
    assign exp_l    = swap ? exp_b : exp_a;
    assign exp_s    = swap ? exp_a : exp_b;
    assign mant_l   = swap ? mant_b : mant_a;
    assign mant_s   = swap ? mant_a : mant_b;
    assign sign_l   = swap ? sign_b : sign_a;
    assign exp_diff = exp_l - exp_s;

    // Past 26 places every bit already sits in the sticky field
    assign shift   = (exp_diff > EXP_W'(FRAC_W+3)) ? 5'(FRAC_W+3) : exp_diff[4:0];
    assign shifted = {mant_s, {(FRAC_W+3){1'b0}}} >> shift;

    assign big_f   = {mant_l, 3'b000};
    assign small_f = {shifted[2*FRAC_W+3 -: FRAC_W+3], |shifted[FRAC_W:0]};

    // Larger magnitude first, so the difference never goes negative
    assign sum = eff_sub ? {1'b0, big_f} - {1'b0, small_f}
                         : {1'b0, big_f} + {1'b0, small_f};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            as_fract <= '0;
            as_exp   <= '0;
            as_sign  <= 1'b0;
        end else begin
            as_fract <= {sum, {(WORK_W-FRAC_W-5){1'b0}}};   // Left aligned
            as_exp   <= $signed({2'b00, exp_l});
            as_sign  <= (eff_sub && sum == '0) ? 1'b0 : sign_l;  // x - x is +0
        end
    end

endmodule

/* fpu_mul_core.sv */
module fpu_mul_core (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [fpu_pkg::WORD_W-1:0]        opa_r,
    input  logic [fpu_pkg::WORD_W-1:0]        opb_r,
    output logic [fpu_pkg::WORK_W-1:0]        mul_prod,
    output logic signed [fpu_pkg::EXP_W+1:0]  mul_exp,
    output logic                              mul_sign
);
    import fpu_pkg::*;

    logic [EXP_W-1:0]        exp_a, exp_b;
    logic [FRAC_W:0]         mant_a, mant_b;
    logic signed [EXP_W+1:0] exp_sum;

    assign exp_a  = opa_r[WORD_W-2 -: EXP_W];
    assign exp_b  = opb_r[WORD_W-2 -: EXP_W];
    assign mant_a = (exp_a == '0) ? '0 : {1'b1, opa_r[FRAC_W-1:0]};
    assign mant_b = (exp_b == '0) ? '0 : {1'b1, opb_r[FRAC_W-1:0]};

    // Two extra bits hold the sign and the carry beyond 255
    assign exp_sum = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b})
                   - $signed((EXP_W+2)'(EXP_BIAS));

    // 1.23 x 1.23 gives 2.46, same point position as the add path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_prod <= '0;
            mul_exp  <= '0;
            mul_sign <= 1'b0;
        end else begin
            mul_prod <= mant_a * mant_b;
            mul_exp  <= exp_sum;
            mul_sign <= opa_r[WORD_W-1] ^ opb_r[WORD_W-1];
        end
    end

endmodule

/* fpu_post_norm.sv */
module fpu_post_norm (
    input  logic                              clk,
    input  logic                              rst_n,
    input  fpu_pkg::fpu_op_t                  op_s2,
    input  logic [fpu_pkg::WORK_W-1:0]        as_fract,
    input  logic signed [fpu_pkg::EXP_W+1:0]  as_exp,
    input  logic                              as_sign,
    input  logic [fpu_pkg::WORK_W-1:0]        mul_prod,
    input  logic signed [fpu_pkg::EXP_W+1:0]  mul_exp,
    input  logic                              mul_sign,
    output logic [fpu_pkg::WORD_W-1:0]        norm_word,
    output logic                              norm_ine,
    output logic                              norm_overflow,
    output logic                              norm_underflow,
    output logic                              norm_zero
);
    import fpu_pkg::*;

    logic                    is_mul, sign_i, zero_in;
    logic [WORK_W-1:0]       fract_i, fract_n;
    logic signed [EXP_W+1:0] exp_i, exp_adj, exp_fin;
    logic [5:0]              lz;
    logic                    guard, rnd, sticky, round_up, inexact;
    logic [FRAC_W+1:0]       mant_r;      // Carry, hidden, fraction
    logic [FRAC_W-1:0]       frac_o;

    assign is_mul  = (op_s2 == OP_MUL);
    assign fract_i = is_mul ? mul_prod : as_fract;
    assign exp_i   = is_mul ? mul_exp  : as_exp;
    assign sign_i  = is_mul ? mul_sign : as_sign;
    assign zero_in = (fract_i == '0);

    ////////////////////////////////////////////////////////////////////////////
    // Leading one search and normalize shift
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        lz = '0;
        for (int i = 0; i < WORK_W; i++) begin
            if (fract_i[i]) begin
                lz = 6'(WORK_W - 1 - i);   // Highest set bit wins
            end
        end
    end

    assign fract_n = fract_i << lz;
    assign exp_adj = exp_i + (EXP_W+2)'(1) - $signed({4'b0000, lz});

    ////////////////////////////////////////////////////////////////////////////
    // Round to nearest even
    ////////////////////////////////////////////////////////////////////////////
    assign guard    = fract_n[WORK_W-FRAC_W-2];
    assign rnd      = fract_n[WORK_W-FRAC_W-3];
    assign sticky   = |fract_n[WORK_W-FRAC_W-4:0];
    assign round_up = guard && (rnd || sticky || fract_n[WORK_W-FRAC_W-1]);
    assign inexact  = guard || rnd || sticky;

    assign mant_r  = {1'b0, fract_n[WORK_W-1 -: FRAC_W+1]} + (FRAC_W+2)'(round_up);
    assign exp_fin = exp_adj + $signed({{(EXP_W+1){1'b0}}, mant_r[FRAC_W+1]});
    // A rounding carry leaves 1.0 with an all-zero fraction
    assign frac_o  = mant_r[FRAC_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            norm_word      <= '0;
            norm_ine       <= 1'b0;
            norm_overflow  <= 1'b0;
            norm_underflow <= 1'b0;
            norm_zero      <= 1'b0;
        end else if (zero_in) begin
            norm_word      <= {sign_i, {(WORD_W-1){1'b0}}};   // Exact zero
            norm_ine       <= 1'b0;
            norm_overflow  <= 1'b0;
            norm_underflow <= 1'b0;
            norm_zero      <= 1'b1;
        end else if (exp_fin >= EXP_MAX) begin
            norm_word      <= {sign_i, EXP_W'(EXP_MAX), {FRAC_W{1'b0}}};
            norm_ine       <= 1'b1;
            norm_overflow  <= 1'b1;
            norm_underflow <= 1'b0;
            norm_zero      <= 1'b0;
        end else if (exp_fin <= 0) begin
            // Flush to zero with no denormal result
            norm_word      <= {sign_i, {(WORD_W-1){1'b0}}};
            norm_ine       <= 1'b1;
            norm_overflow  <= 1'b0;
            norm_underflow <= 1'b1;
            norm_zero      <= 1'b1;
        end else begin
            norm_word      <= {sign_i, exp_fin[EXP_W-1:0], frac_o};
            norm_ine       <= inexact;
            norm_overflow  <= 1'b0;
            norm_underflow <= 1'b0;
            norm_zero      <= 1'b0;
        end
    end

    a_inf_only_ovf: assert property (@(posedge clk) disable iff (!rst_n)
        norm_word[WORD_W-2 -: EXP_W] == EXP_W'(EXP_MAX) |-> norm_overflow);

endmodule

/* fpu_top.sv */
module fpu_top #(
    parameter int PIPE_LATENCY = fpu_pkg::PIPE_LATENCY
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  fpu_pkg::fpu_op_t           fpu_op,
    input  logic [fpu_pkg::WORD_W-1:0] opa,
    input  logic [fpu_pkg::WORD_W-1:0] opb,
    output logic [fpu_pkg::WORD_W-1:0] out,
    output logic                       inf,
    output logic                       snan,
    output logic                       qnan,
    output logic                       ine,
    output logic                       overflow,
    output logic                       underflow,
    output logic                       zero
);
    import fpu_pkg::*;

    logic [WORD_W-1:0]       opa_r, opb_r;
    fpu_op_t                 op_s1, op_s2;
    logic                    special_valid;
    logic [WORD_W-1:0]       special_word;
    logic                    special_inf, special_qnan, special_snan, special_zero;
    logic [WORK_W-1:0]       as_fract, mul_prod;
    logic signed [EXP_W+1:0] as_exp, mul_exp;
    logic                    as_sign, mul_sign;
    logic [WORD_W-1:0]       norm_word;
    logic                    norm_ine, norm_overflow, norm_underflow, norm_zero;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline stages
    ////////////////////////////////////////////////////////////////////////////
    fpu_ctrl_pipe #(.PIPE_LATENCY(PIPE_LATENCY)) u_ctrl (
        .clk, .rst_n, .opa, .opb, .fpu_op,
        .opa_r, .opb_r, .op_s1, .op_s2
    );

    fpu_except u_except (
        .clk, .rst_n, .opa_r, .opb_r, .op_s1,
        .special_valid, .special_word, .special_inf,
        .special_qnan, .special_snan, .special_zero
    );

    fpu_addsub_align u_align (
        .clk, .rst_n, .opa_r, .opb_r, .op_s1,
        .as_fract, .as_exp, .as_sign
    );

    fpu_mul_core u_mul (
        .clk, .rst_n, .opa_r, .opb_r,
        .mul_prod, .mul_exp, .mul_sign
    );

    fpu_post_norm u_norm (
        .clk, .rst_n, .op_s2,
        .as_fract, .as_exp, .as_sign,
        .mul_prod, .mul_exp, .mul_sign,
        .norm_word, .norm_ine, .norm_overflow, .norm_underflow, .norm_zero
    );

    // Output stage, special operands override the computed result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out       <= '0;
            inf       <= 1'b0;
            snan      <= 1'b0;
            qnan      <= 1'b0;
            ine       <= 1'b0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
            zero      <= 1'b0;
        end else if (special_valid) begin
            out       <= special_word;
            inf       <= special_inf;
            snan      <= special_snan;
            qnan      <= special_qnan;
            ine       <= 1'b0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
            zero      <= special_zero;
        end else begin
            out       <= norm_word;
            inf       <= norm_overflow;   // Overflow always yields infinity
            snan      <= 1'b0;
            qnan      <= 1'b0;
            ine       <= norm_ine;
            overflow  <= norm_overflow;
            underflow <= norm_underflow;
            zero      <= norm_zero;
        end
    end

endmodule

/* fpu_tb_vectors.svh */
`ifndef FPU_TB_VECTORS_SVH
`define FPU_TB_VECTORS_SVH

// Flag field order {inf, snan, qnan, ine, overflow, underflow, zero}
localparam logic [6:0] F_NONE = 7'b000_0000;
localparam logic [6:0] F_INF  = 7'b100_0000;
localparam logic [6:0] F_SNAN = 7'b010_0000;
localparam logic [6:0] F_QNAN = 7'b001_0000;
localparam logic [6:0] F_INE  = 7'b000_1000;
localparam logic [6:0] F_OVF  = 7'b000_0100;
localparam logic [6:0] F_UNF  = 7'b000_0010;
localparam logic [6:0] F_ZERO = 7'b000_0001;

typedef struct packed {
    logic [1:0]  op;
    logic [31:0] opa;
    logic [31:0] opb;
    logic [31:0] res;
    logic [6:0]  flags;
} test_vec_t;

// Filler row between table rows
localparam test_vec_t IDLE_VEC  = '{OP_ADD, 32'h0, 32'h0, 32'h0, F_ZERO};
localparam test_vec_t RESET_VEC = '{OP_ADD, 32'h0, 32'h0, 32'h0, F_NONE};

localparam int NUM_VECS = 21;

// Columns: op, opa, opb, expected out, expected flags
localparam test_vec_t VECTORS [NUM_VECS] = '{
    '{OP_ADD, 32'h3fc0_0000, 32'h4010_0000, 32'h4070_0000, F_NONE},  // 1.5 + 2.25
    '{OP_SUB, 32'h40a0_0000, 32'h40a0_0000, 32'h0000_0000, F_ZERO},  // 5 - 5
    '{OP_SUB, 32'h3f80_0000, 32'h4040_0000, 32'hc000_0000, F_NONE},  // 1 - 3
    '{OP_ADD, 32'hc020_0000, 32'h3f80_0000, 32'hbfc0_0000, F_NONE},  // -2.5 + 1
    '{OP_ADD, 32'h3f80_0000, 32'h3080_0000, 32'h3f80_0000, F_INE},   // 1 + 2^-30
    '{OP_MUL, 32'h3f8c_cccd, 32'h3f8c_cccd, 32'h3f9a_e148, F_INE},   // 1.1 * 1.1
    '{OP_MUL, 32'h3f80_0001, 32'h3f80_0001, 32'h3f80_0002, F_INE},   // (1 + ulp)^2
    '{OP_MUL, 32'h3fc0_0000, 32'h3f80_0001, 32'h3fc0_0002, F_INE},   // Tie, rounds up
    '{OP_MUL, 32'h3fc0_0000, 32'h3f80_0003, 32'h3fc0_0004, F_INE},   // Tie, stays even
    '{OP_MUL, 32'h7f7f_ffff, 32'h4000_0000, 32'h7f80_0000, F_INF | F_INE | F_OVF},
    '{OP_MUL, 32'h0080_0000, 32'h3f00_0000, 32'h0000_0000, F_INE | F_UNF | F_ZERO},
    '{OP_ADD, 32'h7fc0_0000, 32'h3f80_0000, 32'h7fc0_0001, F_QNAN},  // qNaN in
    '{OP_MUL, 32'h7f80_0001, 32'h4000_0000, 32'h7fc0_0001, F_QNAN | F_SNAN},
    '{OP_SUB, 32'h7f80_0000, 32'h7f80_0000, 32'h7fc0_0001, F_QNAN},  // inf - inf
    '{OP_MUL, 32'h7f80_0000, 32'h0000_0000, 32'h7fc0_0001, F_QNAN},  // inf * 0
    '{OP_ADD, 32'h7f80_0000, 32'h3f80_0000, 32'h7f80_0000, F_INF},   // inf + 1
    '{OP_SUB, 32'h3f80_0000, 32'h7f80_0000, 32'hff80_0000, F_INF},   // 1 - inf
    '{OP_ADD, 32'h0000_0001, 32'h3f80_0000, 32'h3f80_0000, F_NONE},  // Denormal + 1
    '{OP_MUL, 32'h0000_0001, 32'h4040_0000, 32'h0000_0000, F_ZERO},  // Denormal * 3
    '{OP_MUL, 32'h8000_0000, 32'h4000_0000, 32'h8000_0000, F_ZERO},  // -0 * 2
    '{2'd3,   32'h3fc0_0000, 32'h4010_0000, 32'h4070_0000, F_NONE}   // Reserved op
};

`endif

/* fpu_tb.sv */
module fpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import fpu_pkg::*;

    `include "fpu_tb_vectors.svh"

    localparam int RESET_TIMEOUT = 20;   // Cycles

    logic              clk;
    logic              rst_n;
    fpu_op_t           fpu_op;
    logic [WORD_W-1:0] opa, opb;
    logic [WORD_W-1:0] out;
    logic              inf, snan, qnan, ine, overflow, underflow, zero;

    int          errors;
    int          checks;
    test_vec_t   exp_q [$];   // Rows in flight
    int          id_q [$];

    fpu_top #(.PIPE_LATENCY(PIPE_LATENCY)) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .fpu_op    (fpu_op),
        .opa       (opa),
        .opb       (opb),
        .out       (out),
        .inf       (inf),
        .snan      (snan),
        .qnan      (qnan),
        .ine       (ine),
        .overflow  (overflow),
        .underflow (underflow),
        .zero      (zero)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: got 0x%h, expected 0x%h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    task automatic check_outputs(input test_vec_t v, input string tag);
        check_value({tag, " out"},       out,             v.res);
        check_value({tag, " inf"},       32'(inf),        32'(v.flags[6]));
        check_value({tag, " snan"},      32'(snan),       32'(v.flags[5]));
        check_value({tag, " qnan"},      32'(qnan),       32'(v.flags[4]));
        check_value({tag, " ine"},       32'(ine),        32'(v.flags[3]));
        check_value({tag, " overflow"},  32'(overflow),   32'(v.flags[2]));
        check_value({tag, " underflow"}, 32'(underflow),  32'(v.flags[1]));
        check_value({tag, " zero"},      32'(zero),       32'(v.flags[0]));
    endtask

    // One row per clock, result checked PIPE_LATENCY edges after the drive
    task automatic issue_and_check(input test_vec_t v, input int id);
        test_vec_t done_vec;
        int        done_id;
        string     tag;
        @(posedge clk);
        fpu_op <= fpu_op_t'(v.op);
        opa    <= v.opa;
        opb    <= v.opb;
        exp_q.push_back(v);
        id_q.push_back(id);
        @(negedge clk);   // Outputs settled
        if (exp_q.size() > PIPE_LATENCY) begin
            done_vec = exp_q.pop_front();
            done_id  = id_q.pop_front();
            tag      = (done_id < 0) ? "idle" : $sformatf("row %0d", done_id);
            check_outputs(done_vec, tag);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int wait_cycles;
        void'($urandom(20));
        errors = 0;
        checks = 0;
        rst_n  = 1'b0;
        fpu_op = OP_ADD;
        opa    = '0;
        opb    = '0;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        wait_cycles = 0;
        while (rst_n !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("Verification failed");
            $finish;
        end
        check_outputs(RESET_VEC, "reset");

        for (int i = 0; i < NUM_VECS; i++) begin
            if ($urandom % 4 == 0) begin
                issue_and_check(IDLE_VEC, -1);   // Occasional gap
            end
            issue_and_check(VECTORS[i], i);
        end
        // Flush the last rows out of the pipeline
        repeat (PIPE_LATENCY) issue_and_check(IDLE_VEC, -1);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
fpu_pkg.sv
fpu_ctrl_pipe.sv
fpu_except.sv
fpu_addsub_align.sv
fpu_mul_core.sv
fpu_post_norm.sv
fpu_top.sv
fpu_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fpu_tb
FLIST     = flist.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@! grep -q "Verification failed" $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
